//--- hw/rd_engine_macros.svh
`ifndef RD_ENGINE_MACROS_SVH
`define RD_ENGINE_MACROS_SVH

// APB register window
`define RD_APB_ADDR_W 8
`define RD_APB_DATA_W 32

// Avalon read channel
// Addresses count lines and not bytes
`define RD_MEM_ADDR_W 32
`define RD_MEM_DATA_W 64
`define RD_BURST_W    8

// Lines in flight and the statistic bank
`define RD_LINE_CNT_W 10
`define RD_STAT_W     32
`define RD_NUM_STATS  4

`endif

//--- hw/engine_csr_pkg.sv
`include "rd_engine_macros.svh"

package engine_csr_pkg;

    // Read control fields, most significant byte first
    typedef struct packed {
        logic [7:0] max_active;
        logic [7:0] num_bursts;
        logic [7:0] start_offset;
        logic [7:0] burst_len;
    } rd_ctrl_fields_t;

    // Same word seen raw by the bus and as fields by the generator
    typedef union packed {
        logic [`RD_APB_DATA_W-1:0] raw;
        rd_ctrl_fields_t fields;
    } rd_ctrl_u;

    // Word index is the byte address over 4
    typedef enum logic [`RD_APB_ADDR_W-3:0] {
        RD_BASE = 0, RD_CTRL = 1, ADDR_MASK = 2, ENGINE_CMD = 3, ENGINE_STATUS = 4,
        STAT0 = 5, STAT1 = 6, STAT2 = 7, STAT3 = 8, DATA_SUM = 9
    } csr_index_t;

    // Position in the counter bank
    typedef enum logic [1:0] {
        BURSTS_REQ = 0, LINES_REQ = 1, LINES_RESP = 2, ACTIVE_SUM = 3
    } stat_sel_t;

endpackage

//--- hw/mem_bus_pkg.sv
`include "rd_engine_macros.svh"

package mem_bus_pkg;

    // Line address
    typedef logic [`RD_MEM_ADDR_W-1:0] mem_addr_t;

    // Lines per burst
    typedef logic [`RD_BURST_W-1:0] burst_cnt_t;

    // One returned line
    typedef logic [`RD_MEM_DATA_W-1:0] mem_data_t;

    // Lines requested and not yet returned
    typedef logic [`RD_LINE_CNT_W-1:0] line_cnt_t;

endpackage

//--- hw/stat_counter.sv
`timescale 1ns/1ps
`include "rd_engine_macros.svh"

module stat_counter
#(
    parameter int INCR_W = `RD_LINE_CNT_W,
    parameter int VALUE_W = `RD_STAT_W
)
(
    input  logic clk,
    input  logic state_reset,
    input  logic restart,
    input  logic [INCR_W-1:0] incr_by,
    output logic [VALUE_W-1:0] value
);

    // Increment arrives already registered
    // Value therefore lags its event by two clocks
    always_ff @(posedge clk)
    begin
        if (state_reset || restart)
        begin
            value <= '0;
        end
        else
        begin
            value <= value + VALUE_W'(incr_by);
        end
    end

endmodule

//--- hw/engine_csr_apb.sv
`timescale 1ns/1ps
`include "rd_engine_macros.svh"

module engine_csr_apb
(
    input  logic clk,
    input  logic state_reset,
    // APB completer
    input  logic psel,
    input  logic penable,
    input  logic pwrite,
    input  logic [`RD_APB_ADDR_W-1:0] paddr,
    input  logic [`RD_APB_DATA_W-1:0] pwdata,
    output logic [`RD_APB_DATA_W-1:0] prdata,
    output logic pready,
    output logic pslverr,
    // Engine state for readout
    input  logic active,
    input  logic done,
    input  logic [`RD_NUM_STATS-1:0][`RD_STAT_W-1:0] stat_values,
    input  logic [31:0] data_sum,
    // Configuration and command
    output mem_bus_pkg::mem_addr_t rd_base,
    output engine_csr_pkg::rd_ctrl_u rd_ctrl,
    output mem_bus_pkg::mem_addr_t addr_mask,
    output logic run,
    output logic restart
);

    logic access;
    logic wr_en;
    logic idx_bad;
    logic wr_ro;
    logic [`RD_APB_ADDR_W-3:0] csr_idx;
    logic [1:0] stat_pos;

    // ========================================
    // Decode
    // ========================================

    // No wait states, so every access phase completes
    assign access = psel && penable;
    assign pready = access;
    assign csr_idx = paddr[`RD_APB_ADDR_W-1:2];

    // Past the end of the map
    assign idx_bad = csr_idx > engine_csr_pkg::DATA_SUM;
    // Status, counters and checksum are read only
    assign wr_ro = pwrite && (csr_idx >= engine_csr_pkg::ENGINE_STATUS);
    assign pslverr = access && (idx_bad || wr_ro);
    assign wr_en = access && pwrite && !pslverr;

    // ========================================
    // Configuration and command registers
    // ========================================

    always_ff @(posedge clk)
    begin
        if (state_reset)
        begin
            rd_base <= '0;
            rd_ctrl <= '0;
            addr_mask <= '0;
            run <= 1'b0;
            restart <= 1'b0;
        end
        else
        begin
            // Restart lasts exactly one cycle after the write
            restart <= 1'b0;
            if (wr_en)
            begin
                case (csr_idx)
                    engine_csr_pkg::RD_BASE: rd_base <= pwdata;
                    engine_csr_pkg::RD_CTRL: rd_ctrl.raw <= pwdata;
                    engine_csr_pkg::ADDR_MASK: addr_mask <= pwdata;
                    engine_csr_pkg::ENGINE_CMD:
                    begin
                        run <= pwdata[0];
                        restart <= pwdata[1];
                    end
                    default: ;
                endcase
            end
        end
    end

    // ========================================
    // Read data
    // ========================================

    // Bank slot for STAT0 up to STAT3
    assign stat_pos = 2'(csr_idx - engine_csr_pkg::STAT0);

    always_comb
    begin
        prdata = '0;
        case (csr_idx)
            engine_csr_pkg::RD_BASE: prdata = rd_base;
            engine_csr_pkg::RD_CTRL: prdata = rd_ctrl.raw;
            engine_csr_pkg::ADDR_MASK: prdata = addr_mask;
            // Restart bit is never stored, so it reads as 0
            engine_csr_pkg::ENGINE_CMD: prdata = `RD_APB_DATA_W'(run);
            engine_csr_pkg::ENGINE_STATUS: prdata = `RD_APB_DATA_W'({done, active});
            engine_csr_pkg::STAT0,
            engine_csr_pkg::STAT1,
            engine_csr_pkg::STAT2,
            engine_csr_pkg::STAT3: prdata = stat_values[stat_pos];
            engine_csr_pkg::DATA_SUM: prdata = data_sum;
            default: prdata = '0;
        endcase
    end

endmodule

//--- hw/rd_req_generator.sv
`timescale 1ns/1ps
`include "rd_engine_macros.svh"

module rd_req_generator
(
    input  logic clk,
    input  logic state_reset,
    // Control from the register block
    input  logic run,
    input  logic restart,
    input  mem_bus_pkg::mem_addr_t rd_base,
    input  engine_csr_pkg::rd_ctrl_u rd_ctrl,
    input  mem_bus_pkg::mem_addr_t addr_mask,
    // Avalon read channel
    output logic rd_read,
    output mem_bus_pkg::mem_addr_t rd_address,
    output mem_bus_pkg::burst_cnt_t rd_burstcount,
    input  logic rd_waitrequest,
    input  logic rd_readdatavalid,
    input  mem_bus_pkg::mem_data_t rd_readdata,
    // Status and statistics
    output logic active,
    output logic done,
    output mem_bus_pkg::line_cnt_t [`RD_NUM_STATS-1:0] stat_incr,
    output logic [31:0] data_sum
);

    engine_csr_pkg::rd_ctrl_fields_t ctrl;
    mem_bus_pkg::mem_addr_t cur_offset;
    logic [7:0] bursts_left;
    logic unlimited;
    mem_bus_pkg::line_cnt_t lines_active;
    mem_bus_pkg::line_cnt_t new_req_lines;
    logic [`RD_LINE_CNT_W:0] lines_if_issued;
    logic quota_ok;
    logic accept;

    assign ctrl = rd_ctrl.fields;

    // ========================================
    // Request issue
    // ========================================

    // Lines in flight if this burst were taken now
    // One extra bit so the sum cannot wrap
    assign lines_if_issued = {1'b0, lines_active} + (`RD_LINE_CNT_W+1)'(ctrl.burst_len);
    // Checked every cycle, so the limit is never overshot
    assign quota_ok = (ctrl.max_active == 8'd0) || (lines_if_issued <= ctrl.max_active);

    assign rd_read = run && !done && quota_ok;
    assign rd_address = rd_base + cur_offset;
    assign rd_burstcount = ctrl.burst_len;
    assign accept = rd_read && !rd_waitrequest;
    assign new_req_lines = accept ? mem_bus_pkg::line_cnt_t'(ctrl.burst_len) : '0;

    // Offset and burst budget only move on acceptance
    always_ff @(posedge clk)
    begin
        if (state_reset)
        begin
            cur_offset <= '0;
            bursts_left <= '0;
            unlimited <= 1'b1;
            done <= 1'b0;
        end
        else if (restart)
        begin
            cur_offset <= mem_bus_pkg::mem_addr_t'(ctrl.start_offset);
            bursts_left <= ctrl.num_bursts;
            // Zero bursts means run until run is cleared
            unlimited <= (ctrl.num_bursts == 8'd0);
            done <= 1'b0;
        end
        else if (accept)
        begin
            // Wrap inside the masked window
            cur_offset <= (cur_offset + mem_bus_pkg::mem_addr_t'(ctrl.burst_len)) & addr_mask;
            bursts_left <= bursts_left - 8'd1;
            done <= !unlimited && (bursts_left == 8'd1);
        end
    end

    // ========================================
    // Lines in flight
    // ========================================

    // Up by a burst on acceptance and down by one per returned beat
    always_ff @(posedge clk)
    begin
        if (state_reset || restart)
        begin
            lines_active <= '0;
        end
        else
        begin
            lines_active <= lines_active + new_req_lines
                            - mem_bus_pkg::line_cnt_t'(rd_readdatavalid);
        end
    end

    // Still busy while responses are outstanding
    assign active = (run && !done) || (lines_active != '0);

    // ========================================
    // Statistic events and checksum
    // ========================================

    always_ff @(posedge clk)
    begin
        if (state_reset || restart)
        begin
            // Nothing from before a restart leaks into the bank
            stat_incr <= '0;
            data_sum <= '0;
        end
        else
        begin
            stat_incr[engine_csr_pkg::BURSTS_REQ] <= mem_bus_pkg::line_cnt_t'(accept);
            stat_incr[engine_csr_pkg::LINES_REQ] <= new_req_lines;
            stat_incr[engine_csr_pkg::LINES_RESP] <=
                mem_bus_pkg::line_cnt_t'(rd_readdatavalid);
            // Summed every cycle for Little's Law latency
            stat_incr[engine_csr_pkg::ACTIVE_SUM] <= lines_active;
            // Low word of each beat, modulo 2^32
            if (rd_readdatavalid)
            begin
                data_sum <= data_sum + rd_readdata[31:0];
            end
        end
    end

endmodule

//--- hw/rd_engine_top.sv
`timescale 1ns/1ps
`include "rd_engine_macros.svh"

module rd_engine_top
(
    input  logic clk,
    input  logic state_reset,
    // APB
    input  logic psel,
    input  logic penable,
    input  logic pwrite,
    input  logic [`RD_APB_ADDR_W-1:0] paddr,
    input  logic [`RD_APB_DATA_W-1:0] pwdata,
    output logic [`RD_APB_DATA_W-1:0] prdata,
    output logic pready,
    output logic pslverr,
    // Avalon read channel
    output logic rd_read,
    output mem_bus_pkg::mem_addr_t rd_address,
    output mem_bus_pkg::burst_cnt_t rd_burstcount,
    input  logic rd_waitrequest,
    input  logic rd_readdatavalid,
    input  mem_bus_pkg::mem_data_t rd_readdata
);

    mem_bus_pkg::mem_addr_t rd_base;
    engine_csr_pkg::rd_ctrl_u rd_ctrl;
    mem_bus_pkg::mem_addr_t addr_mask;
    logic run;
    logic restart;
    logic active;
    logic done;
    mem_bus_pkg::line_cnt_t [`RD_NUM_STATS-1:0] stat_incr;
    logic [`RD_NUM_STATS-1:0][`RD_STAT_W-1:0] stat_values;
    logic [31:0] data_sum;

    engine_csr_apb csr0
    (
        .clk(clk),
        .state_reset(state_reset),
        .psel(psel),
        .penable(penable),
        .pwrite(pwrite),
        .paddr(paddr),
        .pwdata(pwdata),
        .prdata(prdata),
        .pready(pready),
        .pslverr(pslverr),
        .active(active),
        .done(done),
        .stat_values(stat_values),
        .data_sum(data_sum),
        .rd_base(rd_base),
        .rd_ctrl(rd_ctrl),
        .addr_mask(addr_mask),
        .run(run),
        .restart(restart)
    );

    rd_req_generator gen0
    (
        .clk(clk),
        .state_reset(state_reset),
        .run(run),
        .restart(restart),
        .rd_base(rd_base),
        .rd_ctrl(rd_ctrl),
        .addr_mask(addr_mask),
        .rd_read(rd_read),
        .rd_address(rd_address),
        .rd_burstcount(rd_burstcount),
        .rd_waitrequest(rd_waitrequest),
        .rd_readdatavalid(rd_readdatavalid),
        .rd_readdata(rd_readdata),
        .active(active),
        .done(done),
        .stat_incr(stat_incr),
        .data_sum(data_sum)
    );

    // ========================================
    // Counter bank, one slot per event
    // ========================================

    for (genvar i = 0; i < `RD_NUM_STATS; i++)
    begin : g_stat
        localparam engine_csr_pkg::stat_sel_t SEL = engine_csr_pkg::stat_sel_t'(i);

        stat_counter
        #(
            .INCR_W(`RD_LINE_CNT_W),
            .VALUE_W(`RD_STAT_W)
        )
        cnt0
        (
            .clk(clk),
            .state_reset(state_reset),
            .restart(restart),
            .incr_by(stat_incr[SEL]),
            .value(stat_values[SEL])
        );
    end

endmodule

//--- verif/tb_mem_responder.sv
`timescale 1ns/1ps
`include "rd_engine_macros.svh"

module tb_mem_responder
(
    input  logic clk,
    input  logic state_reset,
    // Stimulus modes from the testbench
    input  logic random_wait,
    input  logic slow_resp,
    // Avalon read channel, responder side
    input  logic rd_read,
    input  logic [`RD_MEM_ADDR_W-1:0] rd_address,
    input  logic [`RD_BURST_W-1:0] rd_burstcount,
    output logic rd_waitrequest,
    output logic rd_readdatavalid,
    output logic [`RD_MEM_DATA_W-1:0] rd_readdata
);

    logic [31:0] lfsr;
    logic [`RD_MEM_ADDR_W-1:0] addr_q[$];
    logic [`RD_BURST_W-1:0] len_q[$];
    int beat;
    logic bit_a;
    logic bit_b;

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // Accepted bursts wait here in order
    always @(posedge clk)
    begin
        if (!state_reset && rd_read && !rd_waitrequest)
        begin
            addr_q.push_back(rd_address);
            len_q.push_back(rd_burstcount);
        end
    end

    // ========================================
    // Outputs change on the falling edge
    // ========================================

    initial
    begin
        lfsr = 32'hbfa6;
        beat = 0;
        rd_waitrequest = 1'b0;
        rd_readdatavalid = 1'b0;
        rd_readdata = '0;
        forever
        begin
            @(negedge clk);
            // Beat shown last cycle was taken at the rising edge
            if (rd_readdatavalid)
            begin
                beat++;
                if (beat == len_q[0])
                begin
                    void'(addr_q.pop_front());
                    void'(len_q.pop_front());
                    beat = 0;
                end
            end
            rd_waitrequest = 1'b0;
            if (random_wait)
            begin
                lfsr = lfsr_step(lfsr);
                rd_waitrequest = lfsr[0];
            end
            rd_readdatavalid = 1'b0;
            if (addr_q.size() > 0)
            begin
                bit_a = 1'b1;
                bit_b = 1'b1;
                // Slow mode returns a beat one cycle in four on average
                if (slow_resp)
                begin
                    lfsr = lfsr_step(lfsr);
                    bit_a = lfsr[0];
                    lfsr = lfsr_step(lfsr);
                    bit_b = lfsr[0];
                end
                rd_readdatavalid = bit_a && bit_b;
                // Data is the burst address plus the beat index
                rd_readdata = `RD_MEM_DATA_W'(addr_q[0]) + `RD_MEM_DATA_W'(beat);
            end
        end
    end

endmodule

//--- verif/tb_rd_engine.sv
`timescale 1ns/1ps
`include "rd_engine_macros.svh"

module tb_rd_engine;

    // Byte addresses of the register map
    localparam logic [7:0] A_BASE = 8'h00;
    localparam logic [7:0] A_CTRL = 8'h04;
    localparam logic [7:0] A_MASK = 8'h08;
    localparam logic [7:0] A_CMD = 8'h0c;
    localparam logic [7:0] A_STATUS = 8'h10;
    localparam logic [7:0] A_STAT0 = 8'h14;
    localparam logic [7:0] A_STAT1 = 8'h18;
    localparam logic [7:0] A_STAT2 = 8'h1c;
    localparam logic [7:0] A_STAT3 = 8'h20;
    localparam logic [7:0] A_SUM = 8'h24;
    localparam int MAX_CYCLES = 20000;

    logic clk;
    logic state_reset;
    logic psel;
    logic penable;
    logic pwrite;
    logic [`RD_APB_ADDR_W-1:0] paddr;
    logic [`RD_APB_DATA_W-1:0] pwdata;
    logic [`RD_APB_DATA_W-1:0] prdata;
    logic pready;
    logic pslverr;
    logic rd_read;
    logic [`RD_MEM_ADDR_W-1:0] rd_address;
    logic [`RD_BURST_W-1:0] rd_burstcount;
    logic rd_waitrequest;
    logic rd_readdatavalid;
    logic [`RD_MEM_DATA_W-1:0] rd_readdata;
    logic random_wait;
    logic slow_resp;

    // Reference model of the request stream
    logic [31:0] exp_base = '0;
    logic [31:0] exp_offset = '0;
    logic [31:0] exp_mask = '0;
    logic [31:0] exp_addr = '0;
    logic [31:0] exp_sum = '0;
    logic [31:0] exp_active_sum = '0;
    logic [7:0] exp_len = '0;
    logic [7:0] exp_max = '0;
    int accepted = 0;
    int lines_out = 0;
    int stalls = 0;
    int cycles = 0;
    // Request seen stalled at the last edge
    logic held = 1'b0;
    logic [31:0] held_addr = '0;
    logic [7:0] held_len = '0;

    rd_engine_top dut0
    (
        .clk(clk),
        .state_reset(state_reset),
        .psel(psel),
        .penable(penable),
        .pwrite(pwrite),
        .paddr(paddr),
        .pwdata(pwdata),
        .prdata(prdata),
        .pready(pready),
        .pslverr(pslverr),
        .rd_read(rd_read),
        .rd_address(rd_address),
        .rd_burstcount(rd_burstcount),
        .rd_waitrequest(rd_waitrequest),
        .rd_readdatavalid(rd_readdatavalid),
        .rd_readdata(rd_readdata)
    );

    tb_mem_responder resp0
    (
        .clk(clk),
        .state_reset(state_reset),
        .random_wait(random_wait),
        .slow_resp(slow_resp),
        .rd_read(rd_read),
        .rd_address(rd_address),
        .rd_burstcount(rd_burstcount),
        .rd_waitrequest(rd_waitrequest),
        .rd_readdatavalid(rd_readdatavalid),
        .rd_readdata(rd_readdata)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic expect_value(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        assert (got === exp)
        else abort_run($sformatf("[ERROR] %s got 0x%08h expected 0x%08h", name, got, exp));
    endtask

    // Hard stop if a test hangs
    always @(posedge clk)
    begin
        cycles++;
        if (cycles >= MAX_CYCLES)
            abort_run("Timeout: the tests did not finish within the cycle limit");
    end

    // ========================================
    // Request and response monitor
    // ========================================

    always @(posedge clk)
    begin
        if (!state_reset)
        begin
            // A stalled request must hold still
            if (held)
            begin
                assert (rd_read)
                else abort_run("rd_read dropped while waitrequest was high");
                expect_value("rd_address", rd_address, held_addr);
                expect_value("rd_burstcount", 32'(rd_burstcount), 32'(held_len));
            end
            held = rd_read && rd_waitrequest;
            held_addr = rd_address;
            held_len = rd_burstcount;
            if (held)
                stalls++;
            if (rd_read && !rd_waitrequest)
            begin
                exp_addr = exp_base + exp_offset;
                expect_value("rd_address", rd_address, exp_addr);
                expect_value("rd_burstcount", 32'(rd_burstcount), 32'(exp_len));
                // Low word of every beat of this burst
                for (int i = 0; i < exp_len; i++)
                    exp_sum = exp_sum + exp_addr + 32'(i);
                exp_offset = (exp_offset + 32'(exp_len)) & exp_mask;
                lines_out = lines_out + exp_len;
                accepted++;
            end
            if (rd_readdatavalid)
                lines_out--;
            // Lines in flight over the coming cycle
            exp_active_sum = exp_active_sum + 32'(lines_out);
            if (exp_max != 8'd0)
            begin
                assert (lines_out <= exp_max)
                else abort_run($sformatf("[ERROR] lines in flight 0x%0h above max_active 0x%0h",
                                         lines_out, exp_max));
            end
        end
    end

    // ========================================
    // APB access
    // ========================================

    task automatic bus_access(input logic write, input logic [7:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic err);
        @(negedge clk);
        psel = 1'b1;
        penable = 1'b0;
        pwrite = write;
        paddr = addr;
        pwdata = wdata;
        @(negedge clk);
        penable = 1'b1;
        @(posedge clk);
        rdata = prdata;
        err = pslverr;
        assert (pready)
        else abort_run("APB access phase ended without pready");
        @(negedge clk);
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
        logic [31:0] unused;
        logic err;
        bus_access(1'b1, addr, data, unused, err);
        expect_value("pslverr", 32'(err), 32'h0);
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] data);
        logic err;
        bus_access(1'b0, addr, 32'h0, data, err);
        expect_value("pslverr", 32'(err), 32'h0);
    endtask

    // ========================================
    // Engine control helpers
    // ========================================

    // Mode changes land on the rising edge while the responder acts on the falling edge
    task automatic set_responder(input logic wait_on, input logic slow_on);
        @(posedge clk);
        random_wait = wait_on;
        slow_resp = slow_on;
    endtask

    // Configure, restart with run low, then reset the model
    task automatic program_engine(input logic [31:0] base, input logic [31:0] ctrl,
                                  input logic [31:0] mask);
        apb_write(A_BASE, base);
        apb_write(A_CTRL, ctrl);
        apb_write(A_MASK, mask);
        apb_write(A_CMD, 32'h2);
        exp_base = base;
        exp_len = ctrl[7:0];
        exp_offset = 32'(ctrl[15:8]);
        exp_mask = mask;
        exp_max = ctrl[31:24];
        exp_sum = '0;
        exp_active_sum = '0;
        lines_out = 0;
        accepted = 0;
        stalls = 0;
    endtask

    task automatic wait_for_idle();
        logic [31:0] status;
        status = 32'h1;
        while (status[0])
            apb_read(A_STATUS, status);
    endtask

    // Runs a fixed number of bursts and checks the status and counter totals
    task automatic run_fixed(input logic [31:0] base, input logic [31:0] ctrl,
                             input logic [31:0] mask, input int bursts);
        logic [31:0] data;
        program_engine(base, ctrl, mask);
        apb_write(A_CMD, 32'h1);
        wait_for_idle();
        apb_write(A_CMD, 32'h0);
        // Done set and active clear
        apb_read(A_STATUS, data);
        expect_value("ENGINE_STATUS", data, 32'h2);
        expect_value("accepted bursts", 32'(accepted), 32'(bursts));
        apb_read(A_STAT0, data);
        expect_value("BURSTS_REQ", data, 32'(bursts));
        apb_read(A_STAT1, data);
        expect_value("LINES_REQ", data, 32'(bursts * ctrl[7:0]));
        apb_read(A_STAT2, data);
        expect_value("LINES_RESP", data, 32'(bursts * ctrl[7:0]));
        apb_read(A_STAT3, data);
        expect_value("ACTIVE_SUM", data, exp_active_sum);
    endtask

    // ========================================
    // Directed tests
    // ========================================

    task automatic register_access();
        logic [31:0] data;
        logic err;
        expect_value("rd_read", 32'(rd_read), 32'h0);
        apb_write(A_BASE, 32'h1234_5678);
        apb_read(A_BASE, data);
        expect_value("RD_BASE", data, 32'h1234_5678);
        // One line quota blocks four line bursts, so run stays quiet
        apb_write(A_CTRL, 32'h0102_0304);
        apb_read(A_CTRL, data);
        expect_value("RD_CTRL", data, 32'h0102_0304);
        apb_write(A_MASK, 32'h0000_00ff);
        apb_read(A_MASK, data);
        expect_value("ADDR_MASK", data, 32'h0000_00ff);
        apb_write(A_CMD, 32'h3);
        apb_read(A_CMD, data);
        expect_value("ENGINE_CMD", data, 32'h1);
        expect_value("rd_read", 32'(rd_read), 32'h0);
        apb_write(A_CMD, 32'h0);
        // Counter slot is read only
        bus_access(1'b1, A_STAT0, 32'h1, data, err);
        expect_value("pslverr", 32'(err), 32'h1);
        // Index 10 is past the map
        bus_access(1'b0, 8'h28, 32'h0, data, err);
        expect_value("pslverr", 32'(err), 32'h1);
    endtask

    task automatic fixed_run();
        // Start at 12 so the window of 32 wraps on the last burst
        run_fixed(32'h4000_0100, 32'h0006_0c04, 32'h0000_001f, 6);
    endtask

    task automatic data_checksum();
        logic [31:0] data;
        run_fixed(32'h8765_4300, 32'h0008_0008, 32'h0000_003f, 8);
        apb_read(A_SUM, data);
        expect_value("DATA_SUM", data, exp_sum);
    endtask

    task automatic line_quota();
        // Slow returns keep the quota closed most of the time
        set_responder(1'b0, 1'b1);
        run_fixed(32'h0000_2000, 32'h080a_0004, 32'h0000_00ff, 10);
        set_responder(1'b0, 1'b0);
    endtask

    task automatic back_pressure();
        set_responder(1'b1, 1'b0);
        run_fixed(32'h0001_0000, 32'h000c_0503, 32'h0000_007f, 12);
        assert (stalls > 0)
        else abort_run("waitrequest never stalled a request");
        set_responder(1'b0, 1'b0);
    endtask

    task automatic restart_unlimited();
        logic [31:0] data;
        logic [31:0] lines_req;
        // Previous run left the bank nonzero
        program_engine(32'h0000_5000, 32'h0600_0002, 32'h0000_003f);
        for (int i = 0; i < 4; i++)
        begin
            apb_read(A_STAT0 + 8'(4 * i), data);
            expect_value($sformatf("STAT%0d", i), data, 32'h0);
        end
        apb_read(A_SUM, data);
        expect_value("DATA_SUM", data, 32'h0);
        apb_write(A_CMD, 32'h1);
        // Past 256 bursts, so the 8-bit budget wraps
        while (accepted < 300)
            @(negedge clk);
        apb_read(A_STATUS, data);
        expect_value("ENGINE_STATUS", data, 32'h1);
        apb_write(A_CMD, 32'h0);
        wait_for_idle();
        apb_read(A_STATUS, data);
        expect_value("ENGINE_STATUS", data, 32'h0);
        apb_read(A_STAT1, lines_req);
        expect_value("LINES_REQ", lines_req, 32'(accepted * 2));
        apb_read(A_STAT2, data);
        expect_value("LINES_RESP", data, lines_req);
        apb_read(A_SUM, data);
        expect_value("DATA_SUM", data, exp_sum);
    endtask

    initial
    begin
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        random_wait = 1'b0;
        slow_resp = 1'b0;
        state_reset = 1'b1;
        repeat (10) @(negedge clk);
        state_reset = 1'b0;
        register_access();
        fixed_run();
        data_checksum();
        line_quota();
        back_pressure();
        restart_unlimited();
        $display("Simulation passed");
        $finish;
    end

endmodule

//--- vlog.f
+incdir+hw
hw/engine_csr_pkg.sv
hw/mem_bus_pkg.sv
hw/stat_counter.sv
hw/engine_csr_apb.sv
hw/rd_req_generator.sv
hw/rd_engine_top.sv
verif/tb_mem_responder.sv
verif/tb_rd_engine.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing -Wno-fatal
TOP      = tb_rd_engine
FILELIST = vlog.f
OBJ_DIR  = obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "Simulation passed"

clean:
	rm -rf $(OBJ_DIR)
